/* source/sd_dat_pkg.sv */
package sd_dat_pkg;

	parameter int DATA_WIDTH = 32;
	parameter int BLOCK_WIDTH = 4;
	parameter int TIMEOUT_WIDTH = 16;

	typedef enum logic [3:0] {
		RESET = 4'd0,
		IDLE = 4'd1,
		FIFO_READ = 4'd2,
		LOAD_WRITE = 4'd3,
		SEND = 4'd4,
		WAIT_RESPONSE = 4'd5,
		READ = 4'd6,
		READ_FIFO_WRITE = 4'd7,
		READ_WRAPPER_RESET = 4'd8,
		WAIT_ACK = 4'd9,
		SEND_ACK = 4'd10
	} ctrl_state_t;

	parameter logic [1:0] CFG_ADDR_CTRL = 2'd0;
	parameter logic [1:0] CFG_ADDR_TIMEOUT = 2'd1;

	// blocks sit in the low BLOCK_WIDTH bits of the ctrl word
	parameter int CFG_WRITE_READ_BIT = 4;
	parameter int CFG_MULTIPLE_BIT = 5;
	parameter int CFG_START_BIT = 8;
	parameter int CFG_BUSY_BIT = 16;
	parameter int CFG_TIMEOUT_FLAG_BIT = 17;

endpackage

/* source/sd_dat_regs.sv */
`timescale 1ns/10ps

module sd_dat_regs
	import sd_dat_pkg::*;
(
	input logic sd_clock,
	input logic reset,
	input logic cfg_write,
	input logic [1:0] cfg_addr,
	input logic [DATA_WIDTH-1:0] cfg_wdata,
	input logic busy,
	input logic data_timeout,
	output logic [DATA_WIDTH-1:0] cfg_rdata,
	output logic strobe,
	output logic [BLOCK_WIDTH-1:0] blocks,
	output logic write_read,
	output logic multiple,
	output logic [TIMEOUT_WIDTH-1:0] timeout_limit
);

	logic ctrl_write;
	logic timeout_flag;

	assign ctrl_write = cfg_write && (cfg_addr == CFG_ADDR_CTRL);

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			strobe <= 1'b0;
			blocks <= '0;
			write_read <= 1'b0;
			multiple <= 1'b0;
			timeout_limit <= '1;
			timeout_flag <= 1'b0;
		end
		else
		begin
			strobe <= ctrl_write && cfg_wdata[CFG_START_BIT];
			if (ctrl_write)
			begin
				blocks <= cfg_wdata[BLOCK_WIDTH-1:0];
				write_read <= cfg_wdata[CFG_WRITE_READ_BIT];
				multiple <= cfg_wdata[CFG_MULTIPLE_BIT];
			end
			if (cfg_write && (cfg_addr == CFG_ADDR_TIMEOUT))
				timeout_limit <= cfg_wdata[TIMEOUT_WIDTH-1:0];
			// sticky until the next start
			if (strobe)
				timeout_flag <= 1'b0;
			else if (data_timeout)
				timeout_flag <= 1'b1;
		end
	end

	always_comb
	begin
		cfg_rdata = '0;
		case (cfg_addr)
			CFG_ADDR_CTRL:
			begin
				cfg_rdata[BLOCK_WIDTH-1:0] = blocks;
				cfg_rdata[CFG_WRITE_READ_BIT] = write_read;
				cfg_rdata[CFG_MULTIPLE_BIT] = multiple;
				cfg_rdata[CFG_BUSY_BIT] = busy;
				cfg_rdata[CFG_TIMEOUT_FLAG_BIT] = timeout_flag;
			end
			CFG_ADDR_TIMEOUT:
				cfg_rdata[TIMEOUT_WIDTH-1:0] = timeout_limit;
			default:
				cfg_rdata = '0;
		endcase
	end

endmodule

/* source/dat_word_fifo.sv */
`timescale 1ns/10ps

module dat_word_fifo
	import sd_dat_pkg::*;
#(
	parameter int FIFO_DEPTH = 8
)
(
	input logic sd_clock,
	input logic reset,
	input logic tx_push,
	input logic [DATA_WIDTH-1:0] tx_data,
	input logic pop,
	output logic [DATA_WIDTH-1:0] head_data,
	output logic tx_credit
);

	localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

	logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [CNT_WIDTH-1:0] count;
	logic do_pop;

	// an empty pop returns no credit
	assign do_pop = pop && (count != '0);
	assign tx_credit = do_pop;
	assign head_data = mem[rd_ptr];

	always_ff @(posedge sd_clock)
	begin
		if (tx_push)
			mem[wr_ptr] <= tx_data;
	end

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (tx_push)
				wr_ptr <= (wr_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (tx_push && !do_pop)
				count <= count + 1'b1;
			else if (!tx_push && do_pop)
				count <= count - 1'b1;
		end
	end

endmodule

/* source/dat_phys_controller.sv */
`timescale 1ns/10ps

module dat_phys_controller
	import sd_dat_pkg::*;
#(
	parameter int RX_CREDITS_MAX = 4
)
(
	input logic sd_clock,
	input logic reset,
	input logic strobe,
	input logic ack_in,
	input logic idle_in,
	input logic [BLOCK_WIDTH-1:0] blocks,
	input logic write_read,
	input logic multiple,
	input logic [TIMEOUT_WIDTH-1:0] timeout_limit,
	input logic rx_credit,
	input logic transmission_complete,
	input logic reception_complete,
	input logic [DATA_WIDTH-1:0] data_read,
	input logic [DATA_WIDTH-1:0] head_data,
	output logic serial_ready,
	output logic complete,
	output logic ack_out,
	output logic busy,
	output logic data_timeout,
	output logic pop,
	output logic load_send,
	output logic [DATA_WIDTH-1:0] tx_word,
	output logic enable_receive,
	output logic reset_serdes,
	output logic rx_valid,
	output logic [DATA_WIDTH-1:0] rx_data
);

	localparam int CREDIT_WIDTH = $clog2(RX_CREDITS_MAX + 1);

	ctrl_state_t state;
	ctrl_state_t next_state;
	logic [TIMEOUT_WIDTH-1:0] timeout_count;
	logic [BLOCK_WIDTH-1:0] block_count;
	logic [BLOCK_WIDTH:0] blocks_done;
	logic [CREDIT_WIDTH-1:0] rx_count;
	logic waiting;
	logic last_block;
	logic rx_grant;

	assign waiting = (state == WAIT_RESPONSE) || (state == READ);
	assign data_timeout = waiting && !reception_complete && (timeout_count == timeout_limit);
	assign blocks_done = {1'b0, block_count} + 1'b1;
	assign last_block = !multiple || (blocks_done >= {1'b0, blocks});
	assign rx_grant = rx_credit && (rx_count < RX_CREDITS_MAX);

	always_comb
	begin
		next_state = state;
		case (state)
			RESET:
				next_state = IDLE;
			IDLE:
				if (strobe)
					next_state = write_read ? FIFO_READ : READ;
			FIFO_READ:
				next_state = LOAD_WRITE;
			LOAD_WRITE:
				next_state = SEND;
			SEND:
				if (transmission_complete)
					next_state = WAIT_RESPONSE;
			WAIT_RESPONSE, READ:
				if (reception_complete)
					next_state = READ_FIFO_WRITE;
				else if (data_timeout)
					next_state = WAIT_ACK;
			READ_FIFO_WRITE:
				// hold here until the host grants buffer space
				if (rx_valid)
				begin
					if (last_block)
						next_state = WAIT_ACK;
					else if (write_read)
						next_state = FIFO_READ;
					else
						next_state = READ_WRAPPER_RESET;
				end
			READ_WRAPPER_RESET:
				next_state = READ;
			WAIT_ACK:
				if (ack_in)
					next_state = SEND_ACK;
			SEND_ACK:
				next_state = IDLE;
			default:
				next_state = RESET;
		endcase
	end

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			state <= RESET;
			timeout_count <= '0;
			block_count <= '0;
			rx_count <= '0;
		end
		else
		begin
			state <= idle_in ? IDLE : next_state;
			timeout_count <= waiting ? timeout_count + 1'b1 : '0;
			if (state == IDLE)
				block_count <= '0;
			else if (rx_valid)
				block_count <= block_count + 1'b1;
			if (rx_grant && !rx_valid)
				rx_count <= rx_count + 1'b1;
			else if (!rx_grant && rx_valid)
				rx_count <= rx_count - 1'b1;
		end
	end

	// latch the serializer word as it leaves the FIFO
	always_ff @(posedge sd_clock)
	begin
		if (state == FIFO_READ)
			tx_word <= head_data;
	end

	assign serial_ready = (state == IDLE);
	assign busy = (state != IDLE);
	assign complete = (state == WAIT_ACK) || (state == SEND_ACK);
	assign ack_out = (state == SEND_ACK);
	assign pop = (state == FIFO_READ);
	assign load_send = (state == LOAD_WRITE);
	assign enable_receive = waiting;
	assign reset_serdes = (state == RESET) || (state == IDLE) || (state == READ_WRAPPER_RESET)
		|| complete;
	assign rx_valid = (state == READ_FIFO_WRITE) && (rx_count != '0);
	assign rx_data = data_read;

endmodule

/* source/dat_serdes.sv */
`timescale 1ns/10ps

module dat_serdes
	import sd_dat_pkg::*;
(
	input logic sd_clock,
	input logic reset,
	input logic reset_serdes,
	input logic load_send,
	input logic [DATA_WIDTH-1:0] tx_word,
	input logic enable_receive,
	input logic dat_in,
	output logic dat_out,
	output logic dat_oe,
	output logic transmission_complete,
	output logic reception_complete,
	output logic [DATA_WIDTH-1:0] data_read
);

	localparam int TX_CNT_WIDTH = $clog2(DATA_WIDTH + 2);
	localparam int RX_CNT_WIDTH = $clog2(DATA_WIDTH);

	logic [DATA_WIDTH-1:0] tx_shift;
	logic [TX_CNT_WIDTH-1:0] tx_count;
	logic [DATA_WIDTH-1:0] rx_shift;
	logic [RX_CNT_WIDTH-1:0] rx_count;
	logic rx_busy;
	logic rx_last;

	assign rx_last = rx_busy && (rx_count == RX_CNT_WIDTH'(DATA_WIDTH - 1));

	// transmit start bit, data msb first and stop bit
	always_ff @(posedge sd_clock)
	begin
		if (reset || reset_serdes)
		begin
			dat_out <= 1'b1;
			dat_oe <= 1'b0;
			tx_count <= '0;
			transmission_complete <= 1'b0;
		end
		else
		begin
			transmission_complete <= 1'b0;
			if (load_send)
			begin
				dat_out <= 1'b0;
				dat_oe <= 1'b1;
				tx_count <= '0;
			end
			else if (dat_oe)
			begin
				tx_count <= tx_count + 1'b1;
				if (tx_count < DATA_WIDTH)
					dat_out <= tx_shift[DATA_WIDTH-1];
				else if (tx_count == DATA_WIDTH)
					dat_out <= 1'b1;
				else
				begin
					dat_oe <= 1'b0;
					transmission_complete <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge sd_clock)
	begin
		if (load_send)
			tx_shift <= tx_word;
		else if (dat_oe && (tx_count < DATA_WIDTH))
			tx_shift <= {tx_shift[DATA_WIDTH-2:0], 1'b0};
	end

	// receive
	always_ff @(posedge sd_clock)
	begin
		if (reset || reset_serdes)
		begin
			rx_busy <= 1'b0;
			rx_count <= '0;
			reception_complete <= 1'b0;
		end
		else
		begin
			reception_complete <= rx_last;
			if (rx_busy)
			begin
				rx_count <= rx_count + 1'b1;
				if (rx_last)
					rx_busy <= 1'b0;
			end
			else if (enable_receive && !dat_in)
			begin
				rx_busy <= 1'b1;
				rx_count <= '0;
			end
		end
	end

	always_ff @(posedge sd_clock)
	begin
		if (rx_busy)
			rx_shift <= {rx_shift[DATA_WIDTH-2:0], dat_in};
		if (rx_last)
			data_read <= {rx_shift[DATA_WIDTH-2:0], dat_in};
	end

endmodule

/* source/sd_dat_top.sv */
`timescale 1ns/10ps

module sd_dat_top
	import sd_dat_pkg::*;
#(
	parameter int FIFO_DEPTH = 8,
	parameter int RX_CREDITS_MAX = 4
)
(
	input logic sd_clock,
	input logic reset,
	input logic cfg_write,
	input logic [1:0] cfg_addr,
	input logic [DATA_WIDTH-1:0] cfg_wdata,
	output logic [DATA_WIDTH-1:0] cfg_rdata,
	input logic tx_push,
	input logic [DATA_WIDTH-1:0] tx_data,
	output logic tx_credit,
	input logic rx_credit,
	output logic rx_valid,
	output logic [DATA_WIDTH-1:0] rx_data,
	input logic ack_in,
	input logic idle_in,
	output logic serial_ready,
	output logic complete,
	output logic ack_out,
	output logic dat_out,
	output logic dat_oe,
	input logic dat_in
);

	logic strobe;
	logic [BLOCK_WIDTH-1:0] blocks;
	logic write_read;
	logic multiple;
	logic [TIMEOUT_WIDTH-1:0] timeout_limit;
	logic busy;
	logic data_timeout;
	logic pop;
	logic [DATA_WIDTH-1:0] head_data;
	logic load_send;
	logic [DATA_WIDTH-1:0] tx_word;
	logic enable_receive;
	logic reset_serdes;
	logic transmission_complete;
	logic reception_complete;
	logic [DATA_WIDTH-1:0] data_read;

	sd_dat_regs u_regs (
		.sd_clock(sd_clock), .reset(reset), .cfg_write(cfg_write), .cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata), .busy(busy), .data_timeout(data_timeout),
		.cfg_rdata(cfg_rdata), .strobe(strobe), .blocks(blocks), .write_read(write_read),
		.multiple(multiple), .timeout_limit(timeout_limit)
	);

	dat_word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.sd_clock(sd_clock), .reset(reset), .tx_push(tx_push), .tx_data(tx_data),
		.pop(pop), .head_data(head_data), .tx_credit(tx_credit)
	);

	dat_phys_controller #(.RX_CREDITS_MAX(RX_CREDITS_MAX)) u_ctrl (
		.sd_clock(sd_clock), .reset(reset), .strobe(strobe), .ack_in(ack_in),
		.idle_in(idle_in), .blocks(blocks), .write_read(write_read), .multiple(multiple),
		.timeout_limit(timeout_limit), .rx_credit(rx_credit),
		.transmission_complete(transmission_complete),
		.reception_complete(reception_complete), .data_read(data_read),
		.head_data(head_data), .serial_ready(serial_ready), .complete(complete),
		.ack_out(ack_out), .busy(busy), .data_timeout(data_timeout), .pop(pop),
		.load_send(load_send), .tx_word(tx_word), .enable_receive(enable_receive),
		.reset_serdes(reset_serdes), .rx_valid(rx_valid), .rx_data(rx_data)
	);

	dat_serdes u_serdes (
		.sd_clock(sd_clock), .reset(reset), .reset_serdes(reset_serdes),
		.load_send(load_send), .tx_word(tx_word), .enable_receive(enable_receive),
		.dat_in(dat_in), .dat_out(dat_out), .dat_oe(dat_oe),
		.transmission_complete(transmission_complete),
		.reception_complete(reception_complete), .data_read(data_read)
	);

endmodule

/* dv/sd_card_model.sv */
`timescale 1ns/10ps

module sd_card_model
	import sd_dat_pkg::*;
(
	input logic sd_clock,
	input logic dat_out,
	input logic dat_oe,
	input logic silent,
	input logic read_push,
	input logic [DATA_WIDTH-1:0] read_push_word,
	input logic read_go,
	output logic dat_in,
	output logic written_valid,
	output logic [DATA_WIDTH-1:0] written_word
);

	logic [DATA_WIDTH-1:0] read_queue [$];

	// start bit, word msb first, then line back high
	task automatic send_word(input logic [DATA_WIDTH-1:0] word);
		@(posedge sd_clock);
		#1 dat_in = 1'b0;
		for (int i = DATA_WIDTH - 1; i >= 0; i--)
		begin
			@(posedge sd_clock);
			#1 dat_in = word[i];
		end
		@(posedge sd_clock);
		#1 dat_in = 1'b1;
	endtask

	task automatic capture_and_reply();
		logic [DATA_WIDTH-1:0] word;
		word = '0;
		for (int i = 0; i < DATA_WIDTH; i++)
		begin
			@(posedge sd_clock);
			word = {word[DATA_WIDTH-2:0], dat_out};
		end
		// stop bit
		@(posedge sd_clock);
		#1;
		written_word = word;
		written_valid = 1'b1;
		@(posedge sd_clock);
		#1 written_valid = 1'b0;
		if (!silent)
		begin
			repeat (2) @(posedge sd_clock);
			send_word(~word);
		end
	endtask

	initial
	begin
		dat_in = 1'b1;
		written_valid = 1'b0;
		written_word = '0;
		forever
		begin
			@(posedge sd_clock);
			if (read_push)
				read_queue.push_back(read_push_word);
			if (dat_oe && !dat_out)
				capture_and_reply();
			else if (read_go && !silent && (read_queue.size() > 0))
				send_word(read_queue.pop_front());
		end
	end

endmodule

/* dv/sd_dat_tb.sv */
`timescale 1ns/10ps

module sd_dat_tb
	import sd_dat_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int FIFO_DEPTH = 8;
	localparam int RX_CREDITS_MAX = 4;
	localparam int NUM_ROWS = 8;
	localparam logic [1:0] OUT_DONE = 2'd0;
	localparam logic [1:0] OUT_TIMEOUT = 2'd1;
	localparam logic [1:0] OUT_ABORT = 2'd2;

	typedef struct packed {
		logic write_read;
		logic multiple;
		logic [BLOCK_WIDTH-1:0] blocks;
		logic [TIMEOUT_WIDTH-1:0] limit;
		logic [7:0] credit_delay;
		logic [1:0] outcome;
	} transfer_t;

	logic sd_clock;
	logic reset;
	logic cfg_write;
	logic [1:0] cfg_addr;
	logic [DATA_WIDTH-1:0] cfg_wdata;
	logic [DATA_WIDTH-1:0] cfg_rdata;
	logic tx_push;
	logic [DATA_WIDTH-1:0] tx_data;
	logic tx_credit;
	logic rx_credit;
	logic rx_valid;
	logic [DATA_WIDTH-1:0] rx_data;
	logic ack_in;
	logic idle_in;
	logic serial_ready;
	logic complete;
	logic ack_out;
	logic dat_out;
	logic dat_oe;
	logic dat_in;
	logic silent;
	logic read_push;
	logic [DATA_WIDTH-1:0] read_push_word;
	logic read_go;
	logic written_valid;
	logic [DATA_WIDTH-1:0] written_word;

	transfer_t rows [NUM_ROWS];
	logic [DATA_WIDTH-1:0] expected_words [16];
	logic [DATA_WIDTH-1:0] captured [16];
	int captured_n = 0;
	int host_credits = FIFO_DEPTH;
	int cycles = 0;
	int cycle_limit = 1000;

	sd_dat_top #(.FIFO_DEPTH(FIFO_DEPTH), .RX_CREDITS_MAX(RX_CREDITS_MAX)) dut (
		.sd_clock(sd_clock), .reset(reset), .cfg_write(cfg_write), .cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata), .tx_push(tx_push), .tx_data(tx_data),
		.tx_credit(tx_credit), .rx_credit(rx_credit), .rx_valid(rx_valid), .rx_data(rx_data),
		.ack_in(ack_in), .idle_in(idle_in), .serial_ready(serial_ready),
		.complete(complete), .ack_out(ack_out), .dat_out(dat_out), .dat_oe(dat_oe),
		.dat_in(dat_in)
	);

	sd_card_model card (
		.sd_clock(sd_clock), .dat_out(dat_out), .dat_oe(dat_oe), .silent(silent),
		.read_push(read_push), .read_push_word(read_push_word), .read_go(read_go),
		.dat_in(dat_in), .written_valid(written_valid), .written_word(written_word)
	);

	initial
	begin
		sd_clock = 1'b0;
		forever
			#(CLK_PERIOD / 2) sd_clock = ~sd_clock;
	end

	// host side of the transmit credits
	always @(posedge sd_clock)
	begin
		if (tx_credit === 1'b1)
			host_credits = host_credits + 1;
	end

	always @(posedge sd_clock)
	begin
		if ((written_valid === 1'b1) && (captured_n < 16))
		begin
			captured[captured_n] = written_word;
			captured_n = captured_n + 1;
		end
	end

	always @(posedge sd_clock)
	begin
		cycles = cycles + 1;
		if (cycles > cycle_limit)
		begin
			$display("ERROR: the run hung, no end after %0d cycles", cycles);
			$display("Testbench failed");
			$fatal(1);
		end
	end

	task automatic next_cycle();
		@(posedge sd_clock);
		#1;
	endtask

	task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual,
				expected);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic write_register(input logic [1:0] addr, input logic [DATA_WIDTH-1:0] data);
		cfg_write = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
		next_cycle();
		cfg_write = 1'b0;
		cfg_addr = CFG_ADDR_CTRL;
	endtask

	task automatic push_tx_word(input logic [DATA_WIDTH-1:0] word);
		while (host_credits == 0)
			next_cycle();
		tx_push = 1'b1;
		tx_data = word;
		host_credits = host_credits - 1;
		next_cycle();
		tx_push = 1'b0;
	endtask

	task automatic queue_read_word(input logic [DATA_WIDTH-1:0] word);
		read_push = 1'b1;
		read_push_word = word;
		next_cycle();
		read_push = 1'b0;
	endtask

	task automatic request_read();
		read_go = 1'b1;
		next_cycle();
		read_go = 1'b0;
	endtask

	task automatic finish_handshake();
		compare_value(complete, 1, "complete before ack_in");
		compare_value(ack_out, 0, "ack_out waits for ack_in");
		ack_in = 1'b1;
		next_cycle();
		ack_in = 1'b0;
		compare_value(ack_out, 1, "ack_out after ack_in");
		next_cycle();
		compare_value(ack_out, 0, "ack_out lasts one cycle");
		compare_value(serial_ready, 1, "serial_ready back in IDLE");
	endtask

	task automatic run_transfer(input transfer_t t);
		int n;
		int k;
		logic [DATA_WIDTH-1:0] word;
		logic [DATA_WIDTH-1:0] ctrl;
		n = t.multiple ? int'(t.blocks) : 1;
		captured_n = 0;
		silent = (t.outcome != OUT_DONE);
		if (t.outcome == OUT_DONE)
		begin
			for (k = 0; k < n; k++)
			begin
				word = $urandom();
				expected_words[k] = word;
				if (t.write_read)
					push_tx_word(word);
				else
					queue_read_word(word);
			end
		end
		write_register(CFG_ADDR_TIMEOUT, DATA_WIDTH'(t.limit));
		ctrl = '0;
		ctrl[BLOCK_WIDTH-1:0] = t.blocks;
		ctrl[CFG_WRITE_READ_BIT] = t.write_read;
		ctrl[CFG_MULTIPLE_BIT] = t.multiple;
		ctrl[CFG_START_BIT] = 1'b1;
		write_register(CFG_ADDR_CTRL, ctrl);
		while (serial_ready)
			next_cycle();
		compare_value(cfg_rdata[CFG_TIMEOUT_FLAG_BIT], 0, "timeout flag cleared by start");
		case (t.outcome)
			OUT_DONE:
			begin
				if (!t.write_read)
					request_read();
				for (k = 0; k < n; k++)
				begin
					repeat (t.credit_delay)
					begin
						next_cycle();
						compare_value(rx_valid, 0, "no rx_valid while credit withheld");
					end
					rx_credit = 1'b1;
					next_cycle();
					rx_credit = 0;
					while (!rx_valid)
						next_cycle();
					compare_value(rx_data,
						t.write_read ? ~expected_words[k] : expected_words[k], "rx_data");
					next_cycle();
					compare_value(rx_valid, 0, "one word per credit");
					if (!t.write_read && (k < n - 1))
						request_read();
				end
				while (!complete)
					next_cycle();
				if (t.write_read)
				begin
					compare_value(captured_n, n, "words seen by the card");
					for (k = 0; k < n; k++)
						compare_value(captured[k], expected_words[k], "word seen by the card");
					compare_value(host_credits, FIFO_DEPTH, "tx credits returned");
				end
				finish_handshake();
			end
			OUT_TIMEOUT:
			begin
				while (!complete)
					next_cycle();
				compare_value(cfg_rdata[CFG_TIMEOUT_FLAG_BIT], 1, "sticky timeout flag");
				finish_handshake();
			end
			default:
			begin
				repeat (20)
					next_cycle();
				compare_value(cfg_rdata[CFG_BUSY_BIT], 1, "busy before abort");
				idle_in = 1'b1;
				next_cycle();
				idle_in = 1'b0;
				compare_value(serial_ready, 1, "serial_ready after abort");
				compare_value(cfg_rdata[CFG_BUSY_BIT], 0, "busy after abort");
				compare_value(complete, 0, "no complete after abort");
			end
		endcase
	endtask

	initial
	begin
		reset = 1'b1;
		cfg_write = 1'b0;
		cfg_addr = CFG_ADDR_CTRL;
		cfg_wdata = '0;
		tx_push = 1'b0;
		tx_data = '0;
		rx_credit = 1'b0;
		ack_in = 1'b0;
		idle_in = 1'b0;
		silent = 1'b0;
		read_push = 1'b0;
		read_push_word = '0;
		read_go = 1'b0;
		void'($urandom(62351));

		// write_read, multiple, blocks, timeout limit, credit delay, outcome
		rows[0] = {1'b1, 1'b0, 4'd1, 16'd200, 8'd0, OUT_DONE};
		rows[1] = {1'b1, 1'b1, 4'd4, 16'd200, 8'd0, OUT_DONE};
		rows[2] = {1'b0, 1'b0, 4'd1, 16'd200, 8'd0, OUT_DONE};
		rows[3] = {1'b0, 1'b1, 4'd3, 16'd200, 8'd0, OUT_DONE};
		rows[4] = {1'b0, 1'b0, 4'd1, 16'd200, 8'd60, OUT_DONE};
		rows[5] = {1'b0, 1'b0, 4'd1, 16'd50, 8'd0, OUT_TIMEOUT};
		rows[6] = {1'b0, 1'b0, 4'd1, 16'd1000, 8'd0, OUT_ABORT};
		rows[7] = {1'b1, 1'b1, 4'd2, 16'd200, 8'd5, OUT_DONE};

		// a word out and a word back per block, plus margin
		cycle_limit = 20;
		for (int r = 0; r < NUM_ROWS; r++)
			cycle_limit = cycle_limit + (rows[r].multiple ? int'(rows[r].blocks) : 1)
				* (2 * (DATA_WIDTH + 2) + 30 + int'(rows[r].credit_delay))
				+ int'(rows[r].limit) + 60;

		repeat (3) @(posedge sd_clock);
		#1 reset = 1'b0;
		next_cycle();
		compare_value(complete, 0, "complete after reset");
		compare_value(ack_out, 0, "ack_out after reset");
		compare_value(rx_valid, 0, "rx_valid after reset");
		compare_value(tx_credit, 0, "tx_credit after reset");
		compare_value(dat_oe, 0, "dat_oe after reset");
		compare_value(dat_out, 1, "dat_out after reset");
		compare_value(serial_ready, 1, "serial_ready after reset");

		for (int r = 0; r < NUM_ROWS; r++)
			run_transfer(rows[r]);

		$display("Testbench passed");
		$finish;
	end

endmodule

/* sd_dat_top.f */
source/sd_dat_pkg.sv
source/sd_dat_regs.sv
source/dat_word_fifo.sv
source/dat_phys_controller.sv
source/dat_serdes.sv
source/sd_dat_top.sv
dv/sd_card_model.sv
dv/sd_dat_tb.sv

/* Bender.yml */
package:
  name: sd_dat

sources:
  - source/sd_dat_pkg.sv
  - source/sd_dat_regs.sv
  - source/dat_word_fifo.sv
  - source/dat_phys_controller.sv
  - source/dat_serdes.sv
  - source/sd_dat_top.sv
  - target: test
    files:
      - dv/sd_card_model.sv
      - dv/sd_dat_tb.sv
